//--- filelist.f
hdl/rw_task_pkg.sv
hdl/rw_mem_pkg.sv
hdl/rw_fifo.sv
hdl/rw_worker.sv
hdl/line_write_port.sv
hdl/rw_dispatch.sv
hdl/rw_write_stage.sv
sim/rw_write_stage_chk.sv
sim/rw_write_stage_tb.sv

//--- hdl/line_write_port.sv
// Memory write port of the read-write stage.
// Buffers word writes, expands each into a strobed 512-bit line write, and
// queues write responses until dispatch turns them into unlocks.
`default_nettype none

module line_write_port (
   input  wire logic                    clk,
   input  wire logic                    rstn,
   input  wire logic                    word_valid,
   input  wire rw_mem_pkg::word_write_t word,
   output logic                         word_ready,
   output logic                         wvalid,
   input  wire logic                    wready,
   output rw_mem_pkg::line_write_t      wr,
   input  wire logic                    bvalid,
   input  wire rw_task_pkg::thread_id_t bid,
   output logic                         bready,
   output logic                         resp_valid,
   output rw_task_pkg::thread_id_t      resp_id,
   input  wire logic                    resp_pop
);

   rw_mem_pkg::word_write_t head;
   logic                    wq_full;
   logic                    wq_empty;
   logic                    bq_full;
   logic                    bq_empty;
   logic [rw_mem_pkg::LOG_LINE_BYTES-rw_mem_pkg::LOG_RW_WIDTH-1:0] lane;

   rw_fifo #(
      .payload_t (rw_mem_pkg::word_write_t),
      .LOG_DEPTH (rw_mem_pkg::WDATA_LOG_DEPTH)
   ) wdata_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (word_valid & word_ready),
      .wr_data (word),
      .rd_en   (wvalid & wready),
      .rd_data (head),
      .full    (wq_full),
      .empty   (wq_empty)
   );

   assign word_ready = !wq_full;
   assign wvalid     = !wq_empty;

   // Word offset within the line.
   assign lane = head.addr[rw_mem_pkg::LOG_LINE_BYTES-1:rw_mem_pkg::LOG_RW_WIDTH];

   always_comb begin
      wr.addr = head.addr;
      wr.id   = head.id;
      wr.data = '0;
      wr.strb = '0;
      wr.data[lane*rw_mem_pkg::RW_BITS +: rw_mem_pkg::RW_BITS]   = head.data;
      wr.strb[lane*rw_mem_pkg::RW_BYTES +: rw_mem_pkg::RW_BYTES] = '1;  // Only this lane.
   end

   rw_fifo #(
      .payload_t (rw_task_pkg::thread_id_t),
      .LOG_DEPTH (rw_mem_pkg::BID_LOG_DEPTH)
   ) bid_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (bvalid & bready),
      .wr_data (bid),
      .rd_en   (resp_pop),
      .rd_data (resp_id),
      .full    (bq_full),
      .empty   (bq_empty)
   );

   assign bready     = !bq_full;
   assign resp_valid = !bq_empty;

endmodule

`default_nettype wire

//--- hdl/rw_dispatch.sv
// Acceptance and routing for the read-write stage.
// A task is taken only when its word write and its outlet both have room. The
// outlet is the child register for a live normal task with a child, else the
// retirement queue. Write responses become one-cycle unlock pulses.
`default_nettype none

module rw_dispatch (
   input  wire logic                                 clk,
   input  wire logic                                 rstn,
   input  wire logic                                 task_in_valid,
   input  wire rw_task_pkg::rw_write_t               task_in,
   output logic                                      task_in_ready,
   input  wire logic [rw_task_pkg::N_CQ_SLOTS-1:0]   task_aborted,
   input  wire rw_mem_pkg::word_write_t              upd,
   input  wire logic                                 child_valid,
   input  wire rw_task_pkg::task_out_t               child,
   output logic                                      word_valid,
   output rw_mem_pkg::word_write_t                   word,
   input  wire logic                                 word_ready,
   output logic                                      task_out_valid,
   output rw_task_pkg::task_out_t                    task_out,
   input  wire logic                                 task_out_ready,
   output logic                                      finish_valid,
   output rw_task_pkg::finish_t                      finish,
   input  wire logic                                 finish_ready,
   input  wire logic                                 resp_valid,
   input  wire rw_task_pkg::thread_id_t              resp_id,
   output logic                                      resp_pop,
   output logic                                      unlock_valid,
   output rw_task_pkg::thread_id_t                   unlock_thread
);

   logic                 is_undo;
   logic                 aborted;
   logic                 to_child;
   logic                 child_room;
   logic                 outlet_ok;
   logic                 accept;
   logic                 fin_full;
   logic                 fin_empty;
   rw_task_pkg::finish_t fin_entry;

   assign is_undo  = (task_in.desc.ttype == rw_task_pkg::TASK_UNDO_RESTORE);
   assign aborted  = task_aborted[task_in.cq_slot];
   assign to_child = !is_undo & !aborted & child_valid;  // Aborted tasks drop the child.

   assign child_room = !task_out_valid | task_out_ready;  // Empty or draining now.
   assign outlet_ok  = to_child ? child_room : !fin_full;

   assign word_valid    = task_in_valid & outlet_ok;
   assign task_in_ready = task_in_valid & outlet_ok & word_ready;
   assign accept        = task_in_valid & task_in_ready;

   // Undo restores put the saved value back as is.
   always_comb begin
      if (is_undo) begin
         word.addr = task_in.desc.object;
         word.data = task_in.data;
         word.id   = task_in.thread;
      end else begin
         word = upd;
      end
   end

   // Child output register.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_out_valid <= 1'b0;
      end else if (accept & to_child) begin
         task_out_valid <= 1'b1;
      end else if (task_out_ready) begin
         task_out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept & to_child) task_out <= child;
   end

   always_comb begin
      fin_entry.slot            = task_in.cq_slot;
      fin_entry.is_undo_restore = is_undo;
   end

   rw_fifo #(
      .payload_t (rw_task_pkg::finish_t),
      .LOG_DEPTH (rw_task_pkg::FINISH_LOG_DEPTH)
   ) finish_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (accept & !to_child),
      .wr_data (fin_entry),
      .rd_en   (finish_valid & finish_ready),
      .rd_data (finish),
      .full    (fin_full),
      .empty   (fin_empty)
   );

   assign finish_valid = !fin_empty;

   // Every response is consumed at once and unlocks its thread a cycle later.
   assign resp_pop = resp_valid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         unlock_valid <= 1'b0;
      end else begin
         unlock_valid <= resp_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (resp_valid) unlock_thread <= resp_id;
   end

endmodule

`default_nettype wire

//--- hdl/rw_fifo.sv
// Small synchronous FIFO with first-word-fall-through output.
// The payload is a type parameter, so one module serves every queue in the stage.
// Pushes when full and pops when empty are ignored.
`default_nettype none

module rw_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  LOG_DEPTH = 1
) (
   input  wire logic     clk,
   input  wire logic     rstn,
   input  wire logic     wr_en,
   input  wire payload_t wr_data,
   input  wire logic     rd_en,
   output payload_t      rd_data,
   output logic          full,
   output logic          empty
);

   payload_t             mem [2**LOG_DEPTH];
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH:0]   count;
   logic                 push;
   logic                 pop;

   assign push = wr_en & !full;
   assign pop  = rd_en & !empty;

   assign full    = count[LOG_DEPTH];  // Count reaches exactly the depth.
   assign empty   = (count == '0);
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Storage.
   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= wr_data;
   end

endmodule

`default_nettype wire

//--- hdl/rw_mem_pkg.sv
// Memory-side types for the read-write stage.
// A word write is placed into one lane of a strobed 512-bit line.
`default_nettype none

package rw_mem_pkg;

   localparam int LOG_RW_WIDTH    = 2;  // 4-byte accesses.
   localparam int RW_BYTES        = 1 << LOG_RW_WIDTH;
   localparam int RW_BITS         = 8 * RW_BYTES;
   localparam int LOG_LINE_BYTES  = 6;
   localparam int LINE_BITS       = 512;
   localparam int STRB_BITS       = 64;
   localparam int WDATA_LOG_DEPTH = 1;
   localparam int BID_LOG_DEPTH   = 1;

   typedef logic [RW_BITS-1:0] rw_data_t;

   typedef struct packed {
      logic [31:0]             addr;
      rw_data_t                data;
      rw_task_pkg::thread_id_t id;
   } word_write_t;

   typedef struct packed {
      logic [31:0]             addr;
      logic [LINE_BITS-1:0]    data;
      logic [STRB_BITS-1:0]    strb;
      rw_task_pkg::thread_id_t id;
   } line_write_t;

endpackage

`default_nettype wire

//--- hdl/rw_task_pkg.sv
// Task-side types for the read-write stage.
// Covers the incoming task, child tasks, commit-queue slots and retirement records.
// Files refer to these by scoped name.
`default_nettype none

package rw_task_pkg;

   localparam int LOG_CQ_SLOTS     = 4;
   localparam int N_CQ_SLOTS       = 1 << LOG_CQ_SLOTS;
   localparam int FINISH_LOG_DEPTH = 2;  // Retirement queue holds four.

   typedef logic [LOG_CQ_SLOTS-1:0] cq_slot_t;
   typedef logic [3:0]              thread_id_t;  // Also the memory write id.

   typedef enum logic [1:0] {
      TASK_NORMAL       = 2'd0,
      TASK_UNDO_RESTORE = 2'd1
   } task_type_t;

   typedef struct packed {
      task_type_t  ttype;
      logic [31:0] object;  // Byte address of the object.
      logic [31:0] arg;
   } task_desc_t;

   // Incoming task along with the current object value.
   typedef struct packed {
      task_desc_t  desc;
      logic [31:0] data;
      cq_slot_t    cq_slot;
      thread_id_t  thread;
   } rw_write_t;

   typedef struct packed {
      task_desc_t desc;
      cq_slot_t   cq_slot;
      thread_id_t thread;
   } task_out_t;

   typedef struct packed {
      cq_slot_t slot;
      logic     is_undo_restore;
   } finish_t;

endpackage

`default_nettype wire

//--- hdl/rw_worker.sv
// Update logic for normal read-write tasks.
// Adds arg to the object value and, for a nonzero arg, spawns a child task on
// the next word with arg halved. Purely combinational in this version.
`default_nettype none

module rw_worker (
   input  wire logic                    clk,   // For a pipelined variant.
   input  wire logic                    rstn,
   input  wire rw_task_pkg::task_desc_t in_task,
   input  wire rw_mem_pkg::rw_data_t    in_data,
   input  wire rw_task_pkg::thread_id_t in_thread,
   input  wire rw_task_pkg::cq_slot_t   in_cq_slot,
   output rw_mem_pkg::word_write_t      upd,
   output logic                         child_valid,
   output rw_task_pkg::task_out_t       child
);

   rw_task_pkg::task_desc_t child_desc;

   // New object value goes back to the same address under the thread's id.
   always_comb begin
      upd.addr = in_task.object;
      upd.data = in_data + in_task.arg;
      upd.id   = in_thread;
   end

   // Child walks to the next word.
   always_comb begin
      child_desc.ttype  = rw_task_pkg::TASK_NORMAL;
      child_desc.object = in_task.object + 32'(rw_mem_pkg::RW_BYTES);
      child_desc.arg    = in_task.arg >> 1;
   end

   assign child_valid = (in_task.arg != '0);  // Zero arg ends the chain.

   always_comb begin
      child.desc    = child_desc;
      child.cq_slot = in_cq_slot;
      child.thread  = in_thread;
   end

endmodule

`default_nettype wire

//--- hdl/rw_write_stage.sv
// Top level of the read-write tile stage.
// Connects the update worker and the line write port to the dispatch logic.
// All external interfaces are valid/ready except the abort vector and unlock pulse.
`default_nettype none

module rw_write_stage (
   input  wire logic                               clk,
   input  wire logic                               rstn,
   input  wire logic                               task_in_valid,
   input  wire rw_task_pkg::rw_write_t             task_in,
   output logic                                    task_in_ready,
   input  wire logic [rw_task_pkg::N_CQ_SLOTS-1:0] task_aborted,
   output logic                                    task_out_valid,
   output rw_task_pkg::task_out_t                  task_out,
   input  wire logic                               task_out_ready,
   output logic                                    wvalid,
   output rw_mem_pkg::line_write_t                 wr,
   input  wire logic                               wready,
   input  wire logic                               bvalid,
   input  wire rw_task_pkg::thread_id_t            bid,
   output logic                                    bready,
   output logic                                    finish_valid,
   output rw_task_pkg::finish_t                    finish,
   input  wire logic                               finish_ready,
   output logic                                    unlock_valid,
   output rw_task_pkg::thread_id_t                 unlock_thread
);

   rw_mem_pkg::word_write_t upd;
   rw_mem_pkg::word_write_t word;
   rw_task_pkg::task_out_t  child;
   rw_task_pkg::thread_id_t resp_id;
   logic                    child_valid;
   logic                    word_valid;
   logic                    word_ready;
   logic                    resp_valid;
   logic                    resp_pop;

   rw_worker worker (
      .clk         (clk),
      .rstn        (rstn),
      .in_task     (task_in.desc),
      .in_data     (task_in.data),
      .in_thread   (task_in.thread),
      .in_cq_slot  (task_in.cq_slot),
      .upd         (upd),
      .child_valid (child_valid),
      .child       (child)
   );

   line_write_port wport (
      .clk        (clk),
      .rstn       (rstn),
      .word_valid (word_valid),
      .word       (word),
      .word_ready (word_ready),
      .wvalid     (wvalid),
      .wready     (wready),
      .wr         (wr),
      .bvalid     (bvalid),
      .bid        (bid),
      .bready     (bready),
      .resp_valid (resp_valid),
      .resp_id    (resp_id),
      .resp_pop   (resp_pop)
   );

   rw_dispatch dispatch (
      .clk            (clk),
      .rstn           (rstn),
      .task_in_valid  (task_in_valid),
      .task_in        (task_in),
      .task_in_ready  (task_in_ready),
      .task_aborted   (task_aborted),
      .upd            (upd),
      .child_valid    (child_valid),
      .child          (child),
      .word_valid     (word_valid),
      .word           (word),
      .word_ready     (word_ready),
      .task_out_valid (task_out_valid),
      .task_out       (task_out),
      .task_out_ready (task_out_ready),
      .finish_valid   (finish_valid),
      .finish         (finish),
      .finish_ready   (finish_ready),
      .resp_valid     (resp_valid),
      .resp_id        (resp_id),
      .resp_pop       (resp_pop),
      .unlock_valid   (unlock_valid),
      .unlock_thread  (unlock_thread)
   );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compiles the read-write stage and its testbench with Verilator, then runs it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module rw_write_stage_tb -f filelist.f -o rw_sim
output=$(./obj_dir/rw_sim 2>&1 || true)
echo "$output"
if echo "$output" | grep -q '^>>> PASS$'; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

//--- sim/rw_write_stage_chk.sv
// Handshake assertions for the read-write stage, bound into its top level.
// Outputs hold valid and payload until taken, and come up idle after reset.
`default_nettype none

module rw_write_stage_chk (
   input wire logic                    clk,
   input wire logic                    rstn,
   input wire logic                    task_out_valid,
   input wire logic                    task_out_ready,
   input wire rw_task_pkg::task_out_t  task_out,
   input wire logic                    wvalid,
   input wire logic                    wready,
   input wire rw_mem_pkg::line_write_t wr,
   input wire logic                    finish_valid,
   input wire logic                    finish_ready,
   input wire rw_task_pkg::finish_t    finish
);

   a_child_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_out_valid && !task_out_ready |=> task_out_valid && $stable(task_out))
      else $error("Child task dropped or changed before it was taken");

   a_write_hold: assert property (@(posedge clk) disable iff (!rstn)
      wvalid && !wready |=> wvalid && $stable(wr))
      else $error("Line write dropped or changed before it was taken");

   a_finish_hold: assert property (@(posedge clk) disable iff (!rstn)
      finish_valid && !finish_ready |=> finish_valid && $stable(finish))
      else $error("Retirement dropped or changed before it was taken");

   // Queues start empty.
   a_reset_idle: assert property (@(posedge clk) !rstn |=> !wvalid && !finish_valid)
      else $error("Line write or retirement valid in the cycle after reset");

endmodule

bind rw_write_stage rw_write_stage_chk chk (.*);

`default_nettype wire

//--- sim/rw_write_stage_tb.sv
// Testbench for the read-write tile stage.
// Applies a table of tasks under random back-pressure, predicts line writes, child
// tasks, retirements and unlocks from the stage rules, and checks each on its way out.
`default_nettype none

module rw_write_stage_tb;

   localparam int N_ENTRIES = 12;

   typedef struct packed {
      rw_task_pkg::task_type_t ttype;
      rw_task_pkg::cq_slot_t   slot;
      rw_task_pkg::thread_id_t thread;
      logic [31:0]             object;
      logic [31:0]             data;
      logic [31:0]             arg;
      logic                    aborted;
      logic                    exp_child;  // Set when the task should emit a child.
   } entry_t;

   logic                               clk = 1'b0;
   logic                               rstn;
   logic                               task_in_valid;
   rw_task_pkg::rw_write_t             task_in;
   logic                               task_in_ready;
   logic [rw_task_pkg::N_CQ_SLOTS-1:0] task_aborted;
   logic                               task_out_valid;
   rw_task_pkg::task_out_t             task_out;
   logic                               task_out_ready;
   logic                               wvalid;
   rw_mem_pkg::line_write_t            wr;
   logic                               wready;
   logic                               bvalid;
   rw_task_pkg::thread_id_t            bid;
   logic                               bready;
   logic                               finish_valid;
   rw_task_pkg::finish_t               finish;
   logic                               finish_ready;
   logic                               unlock_valid;
   rw_task_pkg::thread_id_t            unlock_thread;

   entry_t                  tbl [N_ENTRIES];
   int                      cur;
   int                      n_accepted = 0;
   int                      n_writes = 0;
   int                      n_children = 0;
   int                      n_finishes = 0;
   int                      n_unlocks = 0;
   rw_task_pkg::thread_id_t sent_ids [N_ENTRIES];  // Ids of line writes in the order sent.
   rw_mem_pkg::line_write_t exp_writes [$];
   rw_task_pkg::task_out_t  exp_children [$];
   rw_task_pkg::finish_t    exp_finishes [$];
   rw_task_pkg::thread_id_t exp_unlocks [$];

   always #4 clk = ~clk;

   rw_write_stage dut (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // One 32-bit word in lane addr[5:2] of an otherwise empty line.
   function automatic rw_mem_pkg::line_write_t line_of(input logic [31:0] addr,
         input logic [31:0] data, input rw_task_pkg::thread_id_t id);
      rw_mem_pkg::line_write_t l;
      int                      lane;
      lane = int'(addr[5:2]);
      l = '0;
      l.addr = addr;
      l.id = id;
      l.data[lane*32 +: 32] = data;
      l.strb[lane*4 +: 4] = 4'hf;
      return l;
   endfunction

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "Stopped at the first failure");
   endtask

   task automatic predict(input entry_t e);
      rw_task_pkg::task_out_t c;
      rw_task_pkg::finish_t   f;
      logic                   undo;
      undo = (e.ttype == rw_task_pkg::TASK_UNDO_RESTORE);
      exp_writes.push_back(line_of(e.object, undo ? e.data : e.data + e.arg, e.thread));
      exp_unlocks.push_back(e.thread);
      if (e.exp_child) begin
         c.desc.ttype  = rw_task_pkg::TASK_NORMAL;
         c.desc.object = e.object + 32'd4;  // Next word.
         c.desc.arg    = e.arg >> 1;
         c.cq_slot     = e.slot;
         c.thread      = e.thread;
         exp_children.push_back(c);
      end else begin
         f.slot            = e.slot;
         f.is_undo_restore = undo;
         exp_finishes.push_back(f);
      end
   endtask

   task automatic check_write(input rw_mem_pkg::line_write_t got,
         input rw_mem_pkg::line_write_t exp);
      int lane;
      lane = int'(exp.addr[5:2]);
      if (got !== exp)
         stop_run($sformatf(
            "Error at %0t: write addr %h strb %h id %h word %h, expected %h %h %h %h",
            $time, got.addr, got.strb, got.id, got.data[lane*32 +: 32],
            exp.addr, exp.strb, exp.id, exp.data[lane*32 +: 32]));
   endtask

   task automatic check_task(input rw_task_pkg::task_out_t got, input rw_task_pkg::task_out_t exp);
      if (got !== exp)
         stop_run($sformatf("Error at %0t: child task %h, expected %h", $time, got, exp));
   endtask

   task automatic check_finish(input rw_task_pkg::finish_t got, input rw_task_pkg::finish_t exp);
      if (got !== exp)
         stop_run($sformatf("Error at %0t: retirement %h, expected %h", $time, got, exp));
   endtask

   task automatic check_unlock(input rw_task_pkg::thread_id_t got,
         input rw_task_pkg::thread_id_t exp);
      if (got !== exp)
         stop_run($sformatf("Error at %0t: unlock thread %h, expected %h", $time, got, exp));
   endtask

   // Handshakes seen mid-cycle complete on the next rising edge.
   always @(negedge clk) begin
      if (rstn) begin
         if (wvalid && wready) begin
            if (exp_writes.size() == 0) stop_run("A line write came out that no task predicts");
            check_write(wr, exp_writes.pop_front());
            sent_ids[n_writes] = wr.id;
            n_writes++;
         end
         if (task_out_valid && task_out_ready) begin
            if (exp_children.size() == 0) stop_run("A child task came out that no task predicts");
            check_task(task_out, exp_children.pop_front());
            n_children++;
         end
         if (finish_valid && finish_ready) begin
            if (exp_finishes.size() == 0) stop_run("A retirement came out that no task predicts");
            check_finish(finish, exp_finishes.pop_front());
            n_finishes++;
         end
         if (unlock_valid) begin
            if (exp_unlocks.size() == 0) stop_run("An unlock pulse came with no write pending");
            check_unlock(unlock_thread, exp_unlocks.pop_front());
            n_unlocks++;
         end
         if (task_in_valid && task_in_ready) begin
            predict(tbl[cur]);
            n_accepted++;
         end
      end
   end

   initial begin : backpressure
      logic [31:0] st;
      st = 32'd46;
      wready = 1'b0;
      task_out_ready = 1'b0;
      finish_ready = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         st = xorshift(st);
         wready         = |st[1:0];  // Ready about three cycles in four.
         task_out_ready = |st[3:2];
         finish_ready   = |st[5:4];
      end
   end

   // Memory side. Answers accepted writes in order after a short random gap.
   initial begin : mem_responder
      logic [31:0] st;
      int          resp_idx;
      int          gap;
      st = xorshift(32'd46);
      resp_idx = 0;
      bvalid = 1'b0;
      bid = '0;
      forever begin
         @(posedge clk);
         #1;
         if (resp_idx < n_writes) begin
            st = xorshift(st);
            gap = int'(st[1:0]);
            repeat (gap) @(posedge clk);
            if (gap != 0) #1;
            bid = sent_ids[resp_idx];
            bvalid = 1'b1;
            resp_idx++;
            @(negedge clk);
            while (!bready) @(negedge clk);
            @(posedge clk);
            #1;
            bvalid = 1'b0;
         end
      end
   end

   initial begin : watchdog
      repeat (200 * N_ENTRIES) @(posedge clk);
      stop_run("Timeout: the stage stopped making progress");
   end

   initial begin : main
      int i;
      //           ttype                           slot  thr    object     data          arg
      tbl[0]  = '{rw_task_pkg::TASK_NORMAL,       4'd1,  4'd3,  32'h1000, 32'h10,       32'h8,
                  1'b0, 1'b1};
      tbl[1]  = '{rw_task_pkg::TASK_NORMAL,       4'd2,  4'd5,  32'h2044, 32'h7,        32'h0,
                  1'b0, 1'b0};
      tbl[2]  = '{rw_task_pkg::TASK_NORMAL,       4'd3,  4'd6,  32'h3038, 32'h100,      32'h5,
                  1'b1, 1'b0};
      tbl[3]  = '{rw_task_pkg::TASK_UNDO_RESTORE, 4'd4,  4'd7,  32'h403c, 32'hdeadbeef, 32'h0,
                  1'b0, 1'b0};
      tbl[4]  = '{rw_task_pkg::TASK_NORMAL,       4'd5,  4'd8,  32'h5004, 32'hffffffff, 32'h2,
                  1'b0, 1'b1};
      tbl[5]  = '{rw_task_pkg::TASK_NORMAL,       4'd6,  4'd9,  32'h6008, 32'h1,        32'h3,
                  1'b0, 1'b1};
      tbl[6]  = '{rw_task_pkg::TASK_UNDO_RESTORE, 4'd7,  4'd10, 32'h7010, 32'h1234,     32'h9,
                  1'b0, 1'b0};
      tbl[7]  = '{rw_task_pkg::TASK_NORMAL,       4'd8,  4'd11, 32'h8020, 32'h55,       32'h0,
                  1'b1, 1'b0};
      tbl[8]  = '{rw_task_pkg::TASK_NORMAL,       4'd9,  4'd12, 32'h9030, 32'ha0,       32'h40,
                  1'b0, 1'b1};
      tbl[9]  = '{rw_task_pkg::TASK_NORMAL,       4'd10, 4'd13, 32'ha02c, 32'h0,        32'h1,
                  1'b1, 1'b0};
      tbl[10] = '{rw_task_pkg::TASK_NORMAL,       4'd0,  4'd0,  32'hb018, 32'h11,       32'h0,
                  1'b0, 1'b0};
      tbl[11] = '{rw_task_pkg::TASK_UNDO_RESTORE, 4'd15, 4'd15, 32'hc03c, 32'h99,       32'h0,
                  1'b1, 1'b0};
      rstn = 1'b0;
      task_in_valid = 1'b0;
      task_in = '0;
      task_aborted = '0;
      cur = 0;
      repeat (2) @(posedge clk);
      #1;
      rstn = 1'b1;
      for (i = 0; i < N_ENTRIES; i++) begin
         cur = i;
         task_in.desc.ttype  = tbl[i].ttype;
         task_in.desc.object = tbl[i].object;
         task_in.desc.arg    = tbl[i].arg;
         task_in.data        = tbl[i].data;
         task_in.cq_slot     = tbl[i].slot;
         task_in.thread      = tbl[i].thread;
         // Other slots carry the opposite abort flag.
         task_aborted  = tbl[i].aborted ? (16'd1 << tbl[i].slot) : ~(16'd1 << tbl[i].slot);
         task_in_valid = 1'b1;
         @(negedge clk);
         while (!task_in_ready) @(negedge clk);
         @(posedge clk);
         #1;
      end
      task_in_valid = 1'b0;
      while (exp_writes.size() + exp_children.size() + exp_finishes.size()
             + exp_unlocks.size() != 0) @(posedge clk);
      repeat (8) @(posedge clk);  // Room for stray outputs to show up.
      if (n_accepted == N_ENTRIES && n_writes == N_ENTRIES && n_unlocks == N_ENTRIES
          && n_children + n_finishes == N_ENTRIES) begin
         $display(">>> PASS");
         $finish;
      end else begin
         stop_run("The number of outputs does not match the number of tasks");
      end
   end

endmodule

`default_nettype wire
